// ==== build.f ====
verilog/cpuPkg.sv
verilog/busPkg.sv
verilog/opDecode.sv
verilog/aluExecute.sv
verilog/regResult.sv
verilog/wbAccumCore.sv
testbench/accumCore_props.sv
testbench/tbTop.sv

// ==== run.sh ====
#!/bin/sh
# compile tbTop with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --assert --top-module tbTop -f build.f -Mdir "$buildDir" -o simTop
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$buildDir/simTop" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "TEST RESULT: FAIL" "$logFile"; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$logFile"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0

// ==== testbench/tbTop.sv ====
// one Wishbone transfer at a time, driven on the falling edge; random operands use a fixed seed
`timescale 1ns/1ps

module tbTop;
    import cpuPkg::*;
    import busPkg::*;

    // about 92 instructions at 13 cycles each plus reset and timing, times 1.6
    localparam int maxCycles = 2000;

    logic phi2;
    logic rstN;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [wbAdrWidth-1:0] wbAdr;
    logic [wbDatInWidth-1:0] wbDatI;
    logic [wbDatOutWidth-1:0] wbDatO;
    logic wbAck;
    int cycleCount = 0;

    // reference model of the visible registers
    logic [7:0] refA;
    logic [7:0] refX;
    logic [7:0] refY;
    logic refN;
    logic refV;
    logic refD;
    logic refI;
    logic refZ;
    logic refC;

    wbAccumCore dut0 (
        .phi2(phi2), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatI(wbDatI), .wbDatO(wbDatO), .wbAck(wbAck)
    );

    bind wbAccumCore accumCore_props props0 (
        .phi2(phi2), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck)
    );

    initial begin
        phi2 = 1'b0;
        forever #5 phi2 = ~phi2;
    end

    // run limit
    always @(posedge phi2) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            reportFailure($sformatf("timeout, run not finished after %0d cycles", maxCycles));
        end
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkByte(input string testName, input logic [7:0] expected,
                             input logic [7:0] actual);
        assert (actual === expected) else begin
            reportFailure($sformatf("ERR %s: expected %02h, actual %02h",
                                    testName, expected, actual));
        end
    endtask

    task automatic checkLatency(input string testName, input int expected, input int actual);
        assert (actual == expected) else begin
            reportFailure($sformatf("ERR %s: expected %0d cycles, actual %0d cycles",
                                    testName, expected, actual));
        end
    endtask

    // packed BCD byte to its decimal value
    function automatic int bcdToInt(input logic [7:0] v);
        return int'(v[7:4]) * 10 + int'(v[3:0]);
    endfunction

    function automatic logic [7:0] intToBcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    // N V 1 0 D I Z C
    function automatic logic [7:0] expectedStatus();
        return {refN, refV, 1'b1, 1'b0, refD, refI, refZ, refC};
    endfunction

    function automatic opcodeT pickCarryOp();
        return ($urandom_range(1, 0) != 0) ? opSec : opClc;
    endfunction

    task automatic updateNZ(input logic [7:0] v);
        refN = v[7];
        refZ = (v == 8'h00);
    endtask

    // expected effect of one instruction on the model
    task automatic modelStep(input opcodeT op, input logic [7:0] imm);
        int bin;
        int sgn;
        int dec;
        logic [7:0] res;
        case (op)
            opAdc, opSbc: begin
                if (op == opAdc) begin
                    bin = int'(refA) + int'(imm) + int'(refC);
                    sgn = int'($signed(refA)) + int'($signed(imm)) + int'(refC);
                    dec = bcdToInt(refA) + bcdToInt(imm) + int'(refC);
                end else begin
                    bin = int'(refA) - int'(imm) - 1 + int'(refC);
                    sgn = int'($signed(refA)) - int'($signed(imm)) - 1 + int'(refC);
                    dec = bcdToInt(refA) - bcdToInt(imm) - 1 + int'(refC);
                end
                // V always from the signed binary result
                refV = (sgn > 127) || (sgn < -128);
                if (refD) begin
                    refC = (op == opAdc) ? (dec > 99) : (dec >= 0);
                    refA = intToBcd((dec + 100) % 100);
                end else begin
                    refC = (op == opAdc) ? (bin > 255) : (bin >= 0);
                    refA = 8'(bin);
                end
            end
            opCmp: begin
                bin = int'(refA) - int'(imm);
                res = 8'(bin);
                refC = (bin >= 0);
                updateNZ(res);
            end
            opAnd: refA = refA & imm;
            opOra: refA = refA | imm;
            opEor: refA = refA ^ imm;
            opLsr: begin
                refC = refA[0];
                refA = {1'b0, refA[7:1]};
            end
            opLda: refA = imm;
            opLdx: refX = imm;
            opLdy: refY = imm;
            opTax: refX = refA;
            opTay: refY = refA;
            opTxa: refA = refX;
            opTya: refA = refY;
            opSec: refC = 1'b1;
            opClc: refC = 1'b0;
            opSed: refD = 1'b1;
            opCld: refD = 1'b0;
            opSei: refI = 1'b1;
            opCli: refI = 1'b0;
            opClv: refV = 1'b0;
            default: ;
        endcase
        // N and Z follow the written register
        case (op)
            opAdc, opSbc, opAnd, opOra, opEor, opLsr, opLda, opTxa, opTya: updateNZ(refA);
            opLdx, opTax: updateNZ(refX);
            opLdy, opTay: updateNZ(refY);
            default: ;
        endcase
    endtask

    // one classic cycle held until ack, ack is taken at the following rising edge
    task automatic busTransfer(input logic we, input logic [wbAdrWidth-1:0] adr,
                               input logic [wbDatInWidth-1:0] dat,
                               output logic [wbDatOutWidth-1:0] rdData, output int latency);
        assert (!wbAck) else begin
            reportFailure("wbAck high before a request was driven");
        end
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbDatI = dat;
        latency = 0;
        do begin
            @(negedge phi2);
            latency++;
        end while (!wbAck);
        rdData = wbDatO;
        @(negedge phi2);
        assert (!wbAck) else begin
            reportFailure("wbAck stayed high for more than one cycle");
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic wbWrite(input logic [wbDatInWidth-1:0] word, output int latency);
        logic [wbDatOutWidth-1:0] ignored;
        busTransfer(1'b1, adrAcc, word, ignored, latency);
    endtask

    task automatic wbRead(input logic [wbAdrWidth-1:0] adr, output logic [7:0] data,
                          output int latency);
        busTransfer(1'b0, adr, '0, data, latency);
    endtask

    // read back all four registers against the model
    task automatic checkState(input string testName);
        logic [7:0] data;
        int latency;
        wbRead(adrAcc, data, latency);
        checkByte({testName, " A"}, refA, data);
        wbRead(adrX, data, latency);
        checkByte({testName, " X"}, refX, data);
        wbRead(adrY, data, latency);
        checkByte({testName, " Y"}, refY, data);
        wbRead(adrStatus, data, latency);
        checkByte({testName, " P"}, expectedStatus(), data);
    endtask

    task automatic runOp(input string testName, input opcodeT op, input logic [7:0] imm);
        int latency;
        modelStep(op, imm);
        wbWrite({op, imm}, latency);
        checkState(testName);
    endtask

    task automatic resetValues();
        checkState("reset");
    endtask

    task automatic loadsAndTransfers();
        runOp("lda negative", opLda, 8'h80);
        runOp("ldx zero", opLdx, 8'h00);
        runOp("ldy random", opLdy, 8'($urandom));
        runOp("tax", opTax, 8'h00);
        runOp("lda zero", opLda, 8'h00);
        runOp("tay", opTay, 8'h00);
        runOp("txa", opTxa, 8'h00);
        runOp("ldy", opLdy, 8'h35);
        runOp("tya", opTya, 8'h00);
    endtask

    task automatic binaryArithmetic();
        int i;
        for (i = 0; i < 5; i++) begin
            runOp("carry before adc", pickCarryOp(), 8'h00);
            runOp("lda random", opLda, 8'($urandom));
            runOp("adc random", opAdc, 8'($urandom));
            runOp("carry before sbc", pickCarryOp(), 8'h00);
            runOp("sbc random", opSbc, 8'($urandom));
        end
        // signed overflow, positive and negative side
        runOp("clc", opClc, 8'h00);
        runOp("lda", opLda, 8'h50);
        runOp("adc overflow", opAdc, 8'h50);
        runOp("sec", opSec, 8'h00);
        runOp("lda", opLda, 8'h50);
        runOp("sbc overflow", opSbc, 8'hB0);
        runOp("lda", opLda, 8'h40);
        runOp("cmp equal", opCmp, 8'h40);
        runOp("cmp below", opCmp, 8'h41);
        runOp("cmp above", opCmp, 8'h10);
        runOp("cmp random", opCmp, 8'($urandom));
    endtask

    task automatic logicAndShift();
        runOp("lda", opLda, 8'hF0);
        runOp("and", opAnd, 8'h3C);
        runOp("ora negative", opOra, 8'h81);
        runOp("eor to zero", opEor, 8'hB1);
        runOp("lda random", opLda, 8'($urandom));
        runOp("and random", opAnd, 8'($urandom));
        runOp("ora random", opOra, 8'($urandom));
        runOp("eor random", opEor, 8'($urandom));
        runOp("lda", opLda, 8'h01);
        runOp("lsr to zero", opLsr, 8'h00);
        runOp("lsr zero", opLsr, 8'h00);
        runOp("lda", opLda, 8'h81);
        runOp("lsr", opLsr, 8'h00);
    endtask

    task automatic decimalMode();
        int i;
        runOp("sed", opSed, 8'h00);
        for (i = 0; i < 4; i++) begin
            runOp("carry before bcd", pickCarryOp(), 8'h00);
            runOp("lda bcd", opLda, intToBcd(int'($urandom_range(99, 0))));
            runOp("adc bcd", opAdc, intToBcd(int'($urandom_range(99, 0))));
            runOp("sbc bcd", opSbc, intToBcd(int'($urandom_range(99, 0))));
        end
        // wrap past 99
        runOp("clc", opClc, 8'h00);
        runOp("lda", opLda, 8'h99);
        runOp("adc bcd wrap", opAdc, 8'h01);
        // back to binary
        runOp("cld", opCld, 8'h00);
        runOp("clc", opClc, 8'h00);
        runOp("lda", opLda, 8'h09);
        runOp("adc binary", opAdc, 8'h01);
    endtask

    task automatic flagOps();
        runOp("sec", opSec, 8'h00);
        runOp("sed", opSed, 8'h00);
        runOp("sei", opSei, 8'h00);
        runOp("clc", opClc, 8'h00);
        runOp("cld", opCld, 8'h00);
        runOp("cli", opCli, 8'h00);
        // V can only be set through an add
        runOp("lda", opLda, 8'h50);
        runOp("adc sets v", opAdc, 8'h50);
        runOp("clv", opClv, 8'h00);
    endtask

    task automatic busTiming();
        logic [7:0] data;
        int latency;
        wbRead(adrX, data, latency);
        checkLatency("read ack", 1, latency);
        checkByte("read data", refX, data);
        modelStep(opLdy, 8'h5A);
        wbWrite({opLdy, 8'h5A}, latency);
        checkLatency("write ack", 4, latency);
        wbRead(adrY, data, latency);
        checkByte("read after write", 8'h5A, data);
    endtask

    initial begin
        void'($urandom(32'h38de32ef));
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatI = '0;
        // state after reset
        refA = 8'h00;
        refX = 8'h00;
        refY = 8'h00;
        refN = 1'b0;
        refV = 1'b0;
        refD = 1'b0;
        refI = 1'b0;
        refZ = 1'b0;
        refC = 1'b0;
        repeat (3) @(posedge phi2);
        @(negedge phi2);
        rstN = 1'b1;
        resetValues();
        loadsAndTransfers();
        binaryArithmetic();
        logicAndShift();
        decimalMode();
        flagOps();
        busTiming();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== testbench/accumCore_props.sv ====
// checks only the Wishbone ack handshake; data values and ack latency are not covered here
`timescale 1ns/1ps

module accumCore_props (
    input logic phi2,
    input logic rstN,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck
);

    // ack is a single-cycle pulse
    ackOneCycle: assert property (
        @(posedge phi2) disable iff (!rstN) wbAck |=> !wbAck
    ) else $error("wbAck stayed high for a second cycle");

    // slave only answers an active request
    ackNeedsRequest: assert property (
        @(posedge phi2) disable iff (!rstN) wbAck |-> (wbCyc && wbStb)
    ) else $error("wbAck high without wbCyc and wbStb");

    // nothing acked while held in reset
    ackLowInReset: assert property (
        @(posedge phi2) !rstN |-> !wbAck
    ) else $error("wbAck high during reset");

endmodule

// ==== verilog/wbAccumCore.sv ====
// Wishbone classic slave; master holds signals until ack, reads ack in 1 cycle, writes in 4
`timescale 1ns/1ps

module wbAccumCore (
    input  logic                             phi2,
    input  logic                             rstN,
    input  logic                             wbCyc,
    input  logic                             wbStb,
    input  logic                             wbWe,
    input  logic [busPkg::wbAdrWidth-1:0]    wbAdr,
    input  logic [busPkg::wbDatInWidth-1:0]  wbDatI,
    output logic [busPkg::wbDatOutWidth-1:0] wbDatO,
    output logic                             wbAck
);
    import cpuPkg::*;
    import busPkg::*;

    busStateT busState;
    logic request;
    logic issue;
    opcodeT instrOp;
    logic [dataWidth-1:0] instrImm;

    // decode stage outputs
    logic decValid;
    aluOpT decAluOp;
    regSelT decSrc;
    regSelT decDst;
    flagClassT decFlags;
    logic [dataWidth-1:0] decOperand;

    // execute stage outputs
    logic exeValid;
    logic [dataWidth-1:0] exeResult;
    logic exeCarry;
    logic exeOvf;
    regSelT exeDst;
    flagClassT exeFlags;

    // committed state
    logic [dataWidth-1:0] accVal;
    logic [dataWidth-1:0] xVal;
    logic [dataWidth-1:0] yVal;
    logic [dataWidth-1:0] statusVal;
    logic commit;

    assign request = wbCyc && wbStb;

    // read ack from the state, write ack on commit unless the master has gone away
    assign wbAck = (busState == busAck)
                || ((busState == busExec) && commit && request);

    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            busState <= busIdle;
            issue <= 1'b0;
        end else begin
            issue <= 1'b0;
            case (busState)
                busIdle: begin
                    if (request && wbWe) begin
                        issue <= 1'b1;
                        busState <= busExec;
                    end else if (request) begin
                        busState <= busAck;
                    end
                end
                // wait for commit even if cyc drops, keeps one instruction in flight
                busExec: begin
                    if (commit) begin
                        busState <= busIdle;
                    end
                end
                default: busState <= busIdle;
            endcase
        end
    end

    // instruction word and read data, captured when accepted
    always_ff @(posedge phi2) begin
        if ((busState == busIdle) && request && wbWe) begin
            instrOp <= opcodeT'(wbDatI[wbDatInWidth-1 -: dataWidth]);
            instrImm <= wbDatI[dataWidth-1:0];
        end
        if ((busState == busIdle) && request && !wbWe) begin
            case (wbAdr)
                adrAcc: wbDatO <= accVal;
                adrX: wbDatO <= xVal;
                adrY: wbDatO <= yVal;
                adrStatus: wbDatO <= statusVal;
                default: wbDatO <= statusVal;
            endcase
        end
    end

    opDecode decode0 (
        .phi2(phi2), .rstN(rstN), .issue(issue), .opcode(instrOp), .operand(instrImm),
        .decValid(decValid), .aluOp(decAluOp), .srcSel(decSrc), .dstSel(decDst),
        .flagClass(decFlags), .operandOut(decOperand)
    );

    aluExecute execute0 (
        .phi2(phi2), .rstN(rstN), .decValid(decValid), .aluOp(decAluOp),
        .srcSel(decSrc), .dstSel(decDst), .flagClass(decFlags), .operandIn(decOperand),
        .accVal(accVal), .xVal(xVal), .yVal(yVal), .statusVal(statusVal),
        .exeValid(exeValid), .resultVal(exeResult), .carryOut(exeCarry), .ovfOut(exeOvf),
        .dstOut(exeDst), .flagClassOut(exeFlags)
    );

    regResult result0 (
        .phi2(phi2), .rstN(rstN), .exeValid(exeValid), .resultVal(exeResult),
        .carryOut(exeCarry), .ovfOut(exeOvf), .dstSel(exeDst), .flagClass(exeFlags),
        .accVal(accVal), .xVal(xVal), .yVal(yVal), .statusVal(statusVal), .commit(commit)
    );

endmodule

// ==== verilog/regResult.sv ====
// commits one result per exeValid; flags outside the instruction's class keep their value
`timescale 1ns/1ps

module regResult (
    input  logic                         phi2,
    input  logic                         rstN,
    input  logic                         exeValid,
    input  logic [cpuPkg::dataWidth-1:0] resultVal,
    input  logic                         carryOut,
    input  logic                         ovfOut,
    input  cpuPkg::regSelT               dstSel,
    input  cpuPkg::flagClassT            flagClass,
    output logic [cpuPkg::dataWidth-1:0] accVal,
    output logic [cpuPkg::dataWidth-1:0] xVal,
    output logic [cpuPkg::dataWidth-1:0] yVal,
    output logic [cpuPkg::dataWidth-1:0] statusVal,
    output logic                         commit
);
    import cpuPkg::*;

    logic flagN;
    logic flagV;
    logic flagD;
    logic flagI;
    logic flagZ;
    logic flagC;
    logic resNeg;
    logic resZero;

    assign resNeg = resultVal[dataWidth-1];
    assign resZero = (resultVal == '0);

    // architectural registers
    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            accVal <= '0;
            xVal <= '0;
            yVal <= '0;
            commit <= 1'b0;
        end else begin
            commit <= exeValid;
            if (exeValid) begin
                case (dstSel)
                    selA: accVal <= resultVal;
                    selX: xVal <= resultVal;
                    selY: yVal <= resultVal;
                    // compare and flag ops write no register
                    default: ;
                endcase
            end
        end
    end

    // flag update, per class
    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            flagN <= 1'b0;
            flagV <= 1'b0;
            flagD <= 1'b0;
            flagI <= 1'b0;
            flagZ <= 1'b0;
            flagC <= 1'b0;
        end else if (exeValid) begin
            case (flagClass)
                fcArith: begin
                    flagN <= resNeg;
                    flagZ <= resZero;
                    flagC <= carryOut;
                    flagV <= ovfOut;
                end
                // N and Z only
                fcLogic, fcLoad: begin
                    flagN <= resNeg;
                    flagZ <= resZero;
                end
                // N Z C, V untouched
                fcCompare, fcShift: begin
                    flagN <= resNeg;
                    flagZ <= resZero;
                    flagC <= carryOut;
                end
                fcSetC: flagC <= 1'b1;
                fcClrC: flagC <= 1'b0;
                fcSetD: flagD <= 1'b1;
                fcClrD: flagD <= 1'b0;
                fcSetI: flagI <= 1'b1;
                fcClrI: flagI <= 1'b0;
                // no set V on the 6502
                fcClrV: flagV <= 1'b0;
                default: ;
            endcase
        end
    end

    // status byte, bit 5 always reads as one, bit 4 (B) not kept
    always_comb begin
        statusVal = 8'h20;
        statusVal[statusN] = flagN;
        statusVal[statusV] = flagV;
        statusVal[statusD] = flagD;
        statusVal[statusI] = flagI;
        statusVal[statusZ] = flagZ;
        statusVal[statusC] = flagC;
    end

endmodule

// ==== verilog/aluExecute.sv ====
// decimal mode applies to ADC and SBC only; BCD results are defined for valid BCD inputs
`timescale 1ns/1ps

module aluExecute (
    input  logic                         phi2,
    input  logic                         rstN,
    input  logic                         decValid,
    input  cpuPkg::aluOpT                aluOp,
    input  cpuPkg::regSelT               srcSel,
    input  cpuPkg::regSelT               dstSel,
    input  cpuPkg::flagClassT            flagClass,
    input  logic [cpuPkg::dataWidth-1:0] operandIn,
    input  logic [cpuPkg::dataWidth-1:0] accVal,
    input  logic [cpuPkg::dataWidth-1:0] xVal,
    input  logic [cpuPkg::dataWidth-1:0] yVal,
    input  logic [cpuPkg::dataWidth-1:0] statusVal,
    output logic                         exeValid,
    output logic [cpuPkg::dataWidth-1:0] resultVal,
    output logic                         carryOut,
    output logic                         ovfOut,
    output cpuPkg::regSelT               dstOut,
    output cpuPkg::flagClassT            flagClassOut
);
    import cpuPkg::*;

    logic [dataWidth-1:0] srcVal;
    logic [dataWidth-1:0] addB;
    logic isSub;
    logic carryIn;
    logic [dataWidth:0] binSum;
    logic [4:0] halfSum;
    logic halfCarry;
    logic binOvf;
    logic decMode;
    logic [dataWidth-1:0] adjSum;
    logic adjCarry;
    logic [dataWidth-1:0] nextResult;
    logic nextCarry;

    // source pick
    always_comb begin
        case (srcSel)
            selA: srcVal = accVal;
            selX: srcVal = xVal;
            selY: srcVal = yVal;
            selOperand: srcVal = operandIn;
            default: srcVal = '0;
        endcase
    end

    // subtract and compare add the inverted operand
    assign isSub = (aluOp == aluSub) || (aluOp == aluCmp);
    assign addB = isSub ? ~srcVal : srcVal;
    // compare ignores C, always a plain A minus operand
    assign carryIn = (aluOp == aluCmp) ? 1'b1 : statusVal[statusC];
    assign binSum = {1'b0, accVal} + {1'b0, addB} + {{dataWidth{1'b0}}, carryIn};
    assign halfSum = {1'b0, accVal[3:0]} + {1'b0, addB[3:0]} + {4'b0000, carryIn};
    assign halfCarry = halfSum[4];

    // same-sign inputs, sum sign flipped
    assign binOvf = (accVal[dataWidth-1] == addB[dataWidth-1])
                 && (accVal[dataWidth-1] != binSum[dataWidth-1]);

    assign decMode = statusVal[statusD] && ((aluOp == aluAdd) || (aluOp == aluSub));

    // decimal adjust on the binary sum
    always_comb begin
        adjSum = binSum[dataWidth-1:0];
        adjCarry = binSum[dataWidth];
        if (decMode && (aluOp == aluAdd)) begin
            if ((binSum[3:0] > 4'd9) || halfCarry) begin
                adjSum = adjSum + bcdLowAdjust;
            end
            // decimal carry also forces C
            if (binSum[dataWidth] || (binSum[dataWidth-1:0] > bcdMax)) begin
                adjSum = adjSum + bcdHighAdjust;
                adjCarry = 1'b1;
            end
        end else if (decMode) begin
            // borrow out of a digit means that digit needs fixing
            if (!halfCarry) begin
                adjSum = adjSum - bcdLowAdjust;
            end
            if (!binSum[dataWidth]) begin
                adjSum = adjSum - bcdHighAdjust;
            end
        end
    end

    // result select, C passes through when the op leaves it alone
    always_comb begin
        nextCarry = statusVal[statusC];
        case (aluOp)
            aluAdd, aluSub, aluCmp: begin
                nextResult = adjSum;
                nextCarry = adjCarry;
            end
            aluAnd: nextResult = accVal & srcVal;
            aluOr: nextResult = accVal | srcVal;
            aluEor: nextResult = accVal ^ srcVal;
            aluShiftRight: begin
                nextResult = {1'b0, srcVal[dataWidth-1:1]};
                nextCarry = srcVal[0];
            end
            aluPass: nextResult = srcVal;
            default: nextResult = srcVal;
        endcase
    end

    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            exeValid <= 1'b0;
        end else begin
            exeValid <= decValid;
        end
    end

    // hold stage between alu and register commit
    always_ff @(posedge phi2) begin
        if (decValid) begin
            resultVal <= nextResult;
            carryOut <= nextCarry;
            ovfOut <= binOvf;
            dstOut <= dstSel;
            flagClassOut <= flagClass;
        end
    end

endmodule

// ==== verilog/opDecode.sv ====
// registers decoded controls one cycle after issue; unknown opcodes still report valid
`timescale 1ns/1ps

module opDecode (
    input  logic                         phi2,
    input  logic                         rstN,
    input  logic                         issue,
    input  cpuPkg::opcodeT               opcode,
    input  logic [cpuPkg::dataWidth-1:0] operand,
    output logic                         decValid,
    output cpuPkg::aluOpT                aluOp,
    output cpuPkg::regSelT               srcSel,
    output cpuPkg::regSelT               dstSel,
    output cpuPkg::flagClassT            flagClass,
    output logic [cpuPkg::dataWidth-1:0] operandOut
);
    import cpuPkg::*;

    aluOpT nextAluOp;
    regSelT nextSrc;
    regSelT nextDst;
    flagClassT nextFlags;

    // alu operation
    always_comb begin
        case (opcode)
            opAdc: nextAluOp = aluAdd;
            opSbc: nextAluOp = aluSub;
            opAnd: nextAluOp = aluAnd;
            opOra: nextAluOp = aluOr;
            opEor: nextAluOp = aluEor;
            opCmp: nextAluOp = aluCmp;
            // loads and transfers just move the source
            opLda, opLdx, opLdy, opTax, opTay, opTxa, opTya: nextAluOp = aluPass;
            opLsr: nextAluOp = aluShiftRight;
            // flag ops and anything unknown
            default: nextAluOp = aluNone;
        endcase
    end

    // operand source, A is always the other adder input
    always_comb begin
        case (opcode)
            opAdc, opSbc, opAnd, opOra, opEor, opCmp: nextSrc = selOperand;
            opLda, opLdx, opLdy: nextSrc = selOperand;
            opTax, opTay, opLsr: nextSrc = selA;
            opTxa: nextSrc = selX;
            opTya: nextSrc = selY;
            default: nextSrc = selNone;
        endcase
    end

    // write-back target, compare writes nothing
    always_comb begin
        case (opcode)
            opAdc, opSbc, opAnd, opOra, opEor: nextDst = selA;
            opLda, opTxa, opTya, opLsr: nextDst = selA;
            opLdx, opTax: nextDst = selX;
            opLdy, opTay: nextDst = selY;
            default: nextDst = selNone;
        endcase
    end

    // flag update class
    always_comb begin
        case (opcode)
            opAdc, opSbc: nextFlags = fcArith;
            opAnd, opOra, opEor: nextFlags = fcLogic;
            opCmp: nextFlags = fcCompare;
            opLda, opLdx, opLdy, opTax, opTay, opTxa, opTya: nextFlags = fcLoad;
            opLsr: nextFlags = fcShift;
            opSec: nextFlags = fcSetC;
            opClc: nextFlags = fcClrC;
            opSed: nextFlags = fcSetD;
            opCld: nextFlags = fcClrD;
            opSei: nextFlags = fcSetI;
            opCli: nextFlags = fcClrI;
            opClv: nextFlags = fcClrV;
            default: nextFlags = fcNone;
        endcase
    end

    // valid follows issue by one cycle
    always_ff @(posedge phi2 or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else begin
            decValid <= issue;
        end
    end

    // decoded fields only matter while decValid is high
    always_ff @(posedge phi2) begin
        if (issue) begin
            aluOp <= nextAluOp;
            srcSel <= nextSrc;
            dstSel <= nextDst;
            flagClass <= nextFlags;
            operandOut <= operand;
        end
    end

endmodule

// ==== verilog/busPkg.sv ====
// Wishbone classic slave map; writes ignore the address, reads return one byte
package busPkg;

    localparam int wbAdrWidth = 2;
    // opcode in the high byte, immediate in the low byte
    localparam int wbDatInWidth = 16;
    localparam int wbDatOutWidth = 8;

    // read address map
    localparam logic [wbAdrWidth-1:0] adrAcc = 2'd0;
    localparam logic [wbAdrWidth-1:0] adrX = 2'd1;
    localparam logic [wbAdrWidth-1:0] adrY = 2'd2;
    localparam logic [wbAdrWidth-1:0] adrStatus = 2'd3;

    // slave handshake states
    typedef enum logic [1:0] {
        busIdle,
        // write in flight through the pipeline
        busExec,
        // read data on the bus, ack high
        busAck
    } busStateT;

endpackage

// ==== verilog/cpuPkg.sv ====
// 6502 immediate and implied subset only; opcodes not listed here execute as a no-op
package cpuPkg;

    // data path width, everything in the core is byte wide
    localparam int dataWidth = 8;

    // status register bit positions, N V 1 0 D I Z C
    localparam int statusN = 7;
    localparam int statusV = 6;
    localparam int statusD = 3;
    localparam int statusI = 2;
    localparam int statusZ = 1;
    localparam int statusC = 0;

    // packed BCD correction constants
    localparam logic [dataWidth-1:0] bcdLowAdjust = 8'h06;
    localparam logic [dataWidth-1:0] bcdHighAdjust = 8'h60;
    // largest legal packed BCD byte
    localparam logic [dataWidth-1:0] bcdMax = 8'h99;

    // supported opcodes, 6502 encodings
    typedef enum logic [7:0] {
        opAdc = 8'h69,
        opSbc = 8'hE9,
        opAnd = 8'h29,
        opOra = 8'h09,
        opEor = 8'h49,
        opCmp = 8'hC9,
        opLda = 8'hA9,
        opLdx = 8'hA2,
        opLdy = 8'hA0,
        opTax = 8'hAA,
        opTay = 8'hA8,
        opTxa = 8'h8A,
        opTya = 8'h98,
        // accumulator form only
        opLsr = 8'h4A,
        opSec = 8'h38,
        opClc = 8'h18,
        opSed = 8'hF8,
        opCld = 8'hD8,
        opSei = 8'h78,
        opCli = 8'h58,
        opClv = 8'hB8
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluEor, aluCmp, aluPass, aluShiftRight, aluNone
    } aluOpT;

    // operand source and write-back target share one encoding
    typedef enum logic [2:0] {
        selA, selX, selY, selOperand, selNone
    } regSelT;

    // which status bits an instruction touches
    typedef enum logic [3:0] {
        fcArith, fcLogic, fcCompare, fcLoad, fcShift,
        fcSetC, fcClrC, fcSetD, fcClrD, fcSetI, fcClrI, fcClrV,
        fcNone
    } flagClassT;

endpackage
